/* verilog.f */
+incdir+.
rf_bus_pkg.sv
rf_ecc_pkg.sv
rf_bus_port.sv
rf_ecc_store.sv
rf_ecc_check.sv
rf_alert.sv
rf_top.sv
rf_tb_clk.sv
rf_tb_asserts.sv
rf_tb.sv

/* rf_tb.sv */
//////////////////////////////
// Register file testbench
// Table of Wishbone accesses with injected faults, checked against a SECDED model
//////////////////////////////

`timescale 1ns/100ps
`include "rf_defs.svh"

module rf_tb;

  typedef struct {
    rf_bus_pkg::rf_op_e      op;
    logic [`RF_ADDR_W-1:0]   addr;
    logic [`RF_DATA_W-1:0]   data;
    logic [`RF_CW_W-1:0]     mask;
    logic [`RF_DATA_W-1:0]   exp_data;
    rf_ecc_pkg::ecc_status_e exp_status;
  } entry_t;

  localparam int resp_timeout = 40;

  logic                  clk, rst_n;
  logic                  fetch_enable, wb_cyc, wb_stb, wb_we;
  logic [`RF_ADDR_W-1:0] wb_adr;
  logic [`RF_DATA_W-1:0] wb_dat_in, wb_dat_out;
  logic                  wb_ack, wb_err;
  logic [`RF_CW_W-1:0]   inj_mask;
  logic                  alert_minor, alert_major, core_sleep;
  logic [7:0]            err_count;

  entry_t              table_q [$];
  logic [`RF_CW_W-1:0] shadow_cw [`RF_NUM_REGS];
  integer              seed;
  logic [7:0]          exp_count;
  logic                exp_major;

  rf_tb_clk u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  rf_top u_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .fetch_enable_i (fetch_enable),
    .wb_cyc_i       (wb_cyc),
    .wb_stb_i       (wb_stb),
    .wb_we_i        (wb_we),
    .wb_adr_i       (wb_adr),
    .wb_dat_i       (wb_dat_in),
    .wb_dat_o       (wb_dat_out),
    .wb_ack_o       (wb_ack),
    .wb_err_o       (wb_err),
    .inj_mask_i     (inj_mask),
    .alert_minor_o  (alert_minor),
    .alert_major_o  (alert_major),
    .err_count_o    (err_count),
    .core_sleep_o   (core_sleep)
  );

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [`RF_DATA_W-1:0] got,
                            input logic [`RF_DATA_W-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got 0x%08h exp 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input rf_ecc_pkg::ecc_status_e got,
                              input rf_ecc_pkg::ecc_status_e exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got 0x%0h exp 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got 0x%02h exp 0x%02h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got 0x%0h exp 0x%0h", name, got, exp));
    end
  endtask

  // Bound protocol assertions stop the run at their first failure
  always @(negedge clk) begin
    if (u_dut.u_asserts.fail_count != 0) begin
      report_failure("a bound protocol assertion failed");
    end
  end

  //////////////////////////////
  // Reference SECDED model
  //////////////////////////////

  // Hamming position of a codeword bit; parity sits at position 0
  function automatic int hamming_pos(input int idx);
    int p;
    int n;
    if (idx == `RF_CW_W - 1) return 0;
    if (idx >= `RF_DATA_W) return 1 << (idx - `RF_DATA_W);
    p = 2;
    n = -1;
    while (n < idx) begin
      p++;
      if ((p & (p - 1)) != 0) n++;
    end
    return p;
  endfunction

  function automatic logic [`RF_CW_W-1:0] encode_word(input logic [`RF_DATA_W-1:0] data);
    logic [`RF_CW_W-1:0] cw;
    int                  syn;
    syn = 0;
    for (int i = 0; i < `RF_DATA_W; i++) begin
      if (data[i]) syn = syn ^ hamming_pos(i);
    end
    cw = {1'b0, 6'(syn), data};
    cw[`RF_CW_W-1] = ^cw[`RF_CW_W-2:0];
    return cw;
  endfunction

  task automatic decode_word(input logic [`RF_CW_W-1:0] cw, output logic [`RF_DATA_W-1:0] data,
                             output rf_ecc_pkg::ecc_status_e status);
    int syn;
    syn = 0;
    for (int i = 0; i < `RF_CW_W; i++) begin
      if (cw[i]) syn = syn ^ hamming_pos(i);
    end
    data = cw[`RF_DATA_W-1:0];
    if (^cw) begin
      status = rf_ecc_pkg::ECC_CORRECTED;
      for (int i = 0; i < `RF_DATA_W; i++) begin
        if (hamming_pos(i) == syn) data[i] = ~data[i];
      end
    end else if (syn != 0) begin
      status = rf_ecc_pkg::ECC_FATAL;
    end else begin
      status = rf_ecc_pkg::ECC_OK;
    end
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  task automatic add_write(input int addr, input logic [`RF_DATA_W-1:0] data,
                           input logic [`RF_CW_W-1:0] mask);
    entry_t e;
    e.op         = rf_bus_pkg::RF_OP_WRITE;
    e.addr       = addr[`RF_ADDR_W-1:0];
    e.data       = data;
    e.mask       = mask;
    e.exp_data   = '0;
    e.exp_status = rf_ecc_pkg::ECC_OK;
    if (addr != 0) shadow_cw[addr] = encode_word(data) ^ mask;
    table_q.push_back(e);
  endtask

  task automatic add_read(input int addr);
    entry_t                  e;
    logic [`RF_DATA_W-1:0]   d;
    rf_ecc_pkg::ecc_status_e s;
    decode_word(shadow_cw[addr], d, s);
    e.op         = rf_bus_pkg::RF_OP_READ;
    e.addr       = addr[`RF_ADDR_W-1:0];
    e.data       = '0;
    e.mask       = '0;
    e.exp_data   = d;
    e.exp_status = s;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    // First entry is issued before fetch enable
    add_read(0);
    for (int r = 1; r <= 6; r++) add_write(r, $random(seed), '0);
    for (int r = 1; r <= 6; r++) add_read(r);
    add_write(0, 32'hdead_beef, '0);
    add_read(0);
    // Single flips on a data bit, the parity bit and a check bit
    add_write(7, $random(seed), 39'h1 << 5);
    add_read(7);
    add_write(8, $random(seed), 39'h1 << 38);
    add_read(8);
    add_write(9, $random(seed), 39'h1 << 33);
    add_read(9);
    // Double flips
    add_write(10, $random(seed), (39'h1 << 3) | (39'h1 << 20));
    add_read(10);
    add_read(1);
    add_read(7);
    add_write(11, $random(seed), (39'h1 << 0) | (39'h1 << 38));
    add_read(11);
    add_read(2);
    add_read(8);
  endtask

  //////////////////////////////
  // Bus sequencing
  //////////////////////////////

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (!rst_n) begin
      @(negedge clk);
      cycles++;
      if (cycles > 20) report_failure("reset was never released");
    end
  endtask

  task automatic wait_response(output int cycles);
    cycles = 0;
    while (!(wb_ack || wb_err)) begin
      @(negedge clk);
      cycles++;
      if (cycles > resp_timeout) begin
        report_failure("no ack or err from the DUT before the timeout");
      end
    end
  endtask

  task automatic run_entry(input entry_t e);
    int                      cycles;
    logic                    held;
    logic                    got_err;
    logic [`RF_DATA_W-1:0]   rdata;
    rf_ecc_pkg::ecc_status_e got_status;
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = (e.op == rf_bus_pkg::RF_OP_WRITE);
    wb_adr    = e.addr;
    wb_dat_in = e.data;
    inj_mask  = e.mask;
    held      = !fetch_enable;
    if (held) begin
      // Request must wait while fetch enable is clear
      repeat (20) begin
        @(negedge clk);
        check_flag("wb_ack_o", wb_ack, 1'b0);
        check_flag("wb_err_o", wb_err, 1'b0);
        check_flag("core_sleep_o", core_sleep, 1'b1);
      end
      fetch_enable = 1'b1;
    end
    wait_response(cycles);
    check_flag("core_sleep_o", core_sleep, 1'b0);
    if (!held) check_count("response latency", 8'(cycles - 1), 8'd2);
    got_err = wb_err;
    rdata   = wb_dat_out;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    inj_mask = '0;

    if (e.op == rf_bus_pkg::RF_OP_READ) begin
      if (e.exp_status == rf_ecc_pkg::ECC_CORRECTED && exp_count != 8'hff) exp_count++;
      if (e.exp_status == rf_ecc_pkg::ECC_FATAL) exp_major = 1'b1;
      check_word("wb_dat_o", rdata, e.exp_data);
    end

    // Alerts follow one cycle after the response
    @(negedge clk);
    if (got_err) got_status = rf_ecc_pkg::ECC_FATAL;
    else if (alert_minor) got_status = rf_ecc_pkg::ECC_CORRECTED;
    else got_status = rf_ecc_pkg::ECC_OK;
    check_status("read status", got_status, e.exp_status);
    check_flag("alert_major_o", alert_major, exp_major);
    check_count("err_count_o", err_count, exp_count);
    check_flag("core_sleep_o", core_sleep, 1'b1);
    @(negedge clk);
    check_flag("alert_minor_o", alert_minor, 1'b0);
  endtask

  initial begin
    fetch_enable = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_in    = '0;
    inj_mask     = '0;
    seed         = 26624;
    exp_count    = '0;
    exp_major    = 1'b0;
    for (int r = 0; r < `RF_NUM_REGS; r++) shadow_cw[r] = '0;
    build_table();

    wait_reset();
    check_flag("core_sleep_o", core_sleep, 1'b1);
    foreach (table_q[i]) run_entry(table_q[i]);
    check_count("err_count_o", err_count, exp_count);
    if (u_dut.u_asserts.fail_count != 0) begin
      report_failure("a bound protocol assertion failed");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

/* rf_tb_asserts.sv */
//////////////////////////////
// Register file assertions
// Bus response and alert protocol checks
//////////////////////////////

`timescale 1ns/100ps

module rf_tb_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic wb_ack_i,
  input logic wb_err_i,
  input logic alert_minor_i,
  input logic alert_major_i
);

  // Failed assertion count
  int unsigned fail_count = 0;

  ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_ack_i && wb_err_i))
  else begin
    $error("ack and err high together");
    fail_count++;
  end

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |=> !wb_ack_i)
  else begin
    $error("ack held longer than one cycle");
    fail_count++;
  end

  err_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_err_i |=> !wb_err_i)
  else begin
    $error("err held longer than one cycle");
    fail_count++;
  end

  // Sticky until reset
  major_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_major_i |=> alert_major_i)
  else begin
    $error("major alert dropped");
    fail_count++;
  end

  minor_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_minor_i |=> !alert_minor_i)
  else begin
    $error("minor alert longer than one cycle");
    fail_count++;
  end

endmodule

bind rf_top rf_tb_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .wb_ack_i      (wb_ack_o),
  .wb_err_i      (wb_err_o),
  .alert_minor_i (alert_minor_o),
  .alert_major_i (alert_major_o)
);

/* rf_tb_clk.sv */
//////////////////////////////
// Testbench clock and reset
//////////////////////////////

`timescale 1ns/100ps

module rf_tb_clk (
  output logic clk_o,
  output logic rst_no
);

  localparam real half_period_ns = 4.0;

  initial begin
    clk_o = 1'b0;
    forever #(half_period_ns) clk_o = ~clk_o;
  end

  // Five rising edges in reset, released away from the falling edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

/* rf_top.sv */
//////////////////////////////
// Register file top
// ECC protected registers behind a Wishbone port
//////////////////////////////

`timescale 1ns/100ps
`include "rf_defs.svh"

module rf_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`RF_ADDR_W-1:0] wb_adr_i,
  input  logic [`RF_DATA_W-1:0] wb_dat_i,
  output logic [`RF_DATA_W-1:0] wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o,
  input  logic [`RF_CW_W-1:0]   inj_mask_i,
  output logic                  alert_minor_o,
  output logic                  alert_major_o,
  output logic [7:0]            err_count_o,
  output logic                  core_sleep_o
);

  logic                    req;
  rf_bus_pkg::rf_op_e      op;
  logic [`RF_ADDR_W-1:0]   addr;
  logic [`RF_DATA_W-1:0]   wdata;
  rf_ecc_pkg::ecc_word_t   rd_word;
  logic [`RF_DATA_W-1:0]   rd_data;
  rf_ecc_pkg::ecc_status_e rd_status;
  logic                    rd_valid;

  rf_bus_port u_bus_port (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_we_i        (wb_we_i),
    .wb_adr_i       (wb_adr_i),
    .wb_dat_i       (wb_dat_i),
    .rd_data_i      (rd_data),
    .rd_status_i    (rd_status),
    .wb_dat_o       (wb_dat_o),
    .wb_ack_o       (wb_ack_o),
    .wb_err_o       (wb_err_o),
    .req_o          (req),
    .op_o           (op),
    .addr_o         (addr),
    .wdata_o        (wdata),
    .rd_valid_o     (rd_valid),
    .core_sleep_o   (core_sleep_o)
  );

  rf_ecc_store u_store (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req),
    .op_i       (op),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .inj_mask_i (inj_mask_i),
    .rd_word_o  (rd_word)
  );

  rf_ecc_check u_check (
    .rd_word_i   (rd_word),
    .rd_data_o   (rd_data),
    .rd_status_o (rd_status)
  );

  rf_alert u_alert (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_valid_i    (rd_valid),
    .rd_status_i   (rd_status),
    .alert_minor_o (alert_minor_o),
    .alert_major_o (alert_major_o),
    .err_count_o   (err_count_o)
  );

endmodule

/* rf_alert.sv */
//////////////////////////////
// Alert unit
// Minor and major alerts, corrected error count
//////////////////////////////

`timescale 1ns/100ps

module rf_alert (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    rd_valid_i,
  input  rf_ecc_pkg::ecc_status_e rd_status_i,
  output logic                    alert_minor_o,
  output logic                    alert_major_o,
  output logic [7:0]              err_count_o
);

  logic                    valid_q;
  rf_ecc_pkg::ecc_status_e status_q;
  logic                    minor_hit, major_hit;
  logic                    alert_minor_q, alert_major_q;
  logic [7:0]              err_count_q;

  // First stage samples alongside the ack, outputs follow a cycle later
  assign minor_hit = valid_q & (status_q == rf_ecc_pkg::ECC_CORRECTED);
  assign major_hit = valid_q & (status_q == rf_ecc_pkg::ECC_FATAL);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q       <= 1'b0;
      status_q      <= rf_ecc_pkg::ECC_OK;
      alert_minor_q <= 1'b0;
      alert_major_q <= 1'b0;
      err_count_q   <= '0;
    end else begin
      valid_q       <= rd_valid_i;
      status_q      <= rd_status_i;
      alert_minor_q <= minor_hit;
      alert_major_q <= alert_major_q | major_hit;
      if (minor_hit && (err_count_q != 8'hff)) begin
        err_count_q <= err_count_q + 8'd1;
      end
    end
  end

  assign alert_minor_o = alert_minor_q;
  assign alert_major_o = alert_major_q;
  assign err_count_o   = err_count_q;

endmodule

/* rf_ecc_check.sv */
//////////////////////////////
// ECC check
// Syndrome decode, single-bit repair, error class
//////////////////////////////

`timescale 1ns/100ps
`include "rf_defs.svh"

module rf_ecc_check (
  input  rf_ecc_pkg::ecc_word_t   rd_word_i,
  output logic [`RF_DATA_W-1:0]   rd_data_o,
  output rf_ecc_pkg::ecc_status_e rd_status_o
);

  rf_ecc_pkg::ecc_syndrome_t pos_tab [`RF_DATA_W];
  rf_ecc_pkg::ecc_syndrome_t walk;
  rf_ecc_pkg::ecc_syndrome_t syndrome;
  logic [`RF_DATA_W-1:0]     flip_mask;
  logic                      parity_err;

  // Codeword position of each data bit, skipping check bit slots
  always_comb begin
    walk = 6'd2;
    for (int i = 0; i < `RF_DATA_W; i++) begin
      walk = walk + 6'd1;
      if ((walk & (walk - 6'd1)) == 6'd0) begin
        walk = walk + 6'd1;
      end
      pos_tab[i] = walk;
    end
  end

  //////////////////////////////
  // Syndrome
  //////////////////////////////

  // Stored check bits against the positions of the set data bits
  always_comb begin
    syndrome = rd_word_i.check;
    for (int i = 0; i < `RF_DATA_W; i++) begin
      if (rd_word_i.data[i]) begin
        syndrome = syndrome ^ pos_tab[i];
      end
    end
  end

  // Even parity over all 39 bits
  assign parity_err = ^rd_word_i;

  //////////////////////////////
  // Repair and classify
  //////////////////////////////

  // Flip only on an odd error count; check bit hits match no data slot
  always_comb begin
    for (int i = 0; i < `RF_DATA_W; i++) begin
      flip_mask[i] = parity_err & (pos_tab[i] == syndrome);
    end
  end

  assign rd_data_o = rd_word_i.data ^ flip_mask;

  always_comb begin
    if (parity_err) begin
      rd_status_o = rf_ecc_pkg::ECC_CORRECTED;
    end else if (syndrome != '0) begin
      // Double error, raw data goes back
      rd_status_o = rf_ecc_pkg::ECC_FATAL;
    end else begin
      rd_status_o = rf_ecc_pkg::ECC_OK;
    end
  end

endmodule

/* rf_ecc_store.sv */
//////////////////////////////
// ECC register store
// SECDED encode, fault injection and codeword array
//////////////////////////////

`timescale 1ns/100ps
`include "rf_defs.svh"

module rf_ecc_store (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  rf_bus_pkg::rf_op_e     op_i,
  input  logic [`RF_ADDR_W-1:0]  addr_i,
  input  logic [`RF_DATA_W-1:0]  wdata_i,
  input  logic [`RF_CW_W-1:0]    inj_mask_i,
  output rf_ecc_pkg::ecc_word_t  rd_word_o
);

  rf_ecc_pkg::ecc_word_t     mem_q [`RF_NUM_REGS];
  rf_ecc_pkg::ecc_word_t     enc_word, wr_word, rd_word_q;
  rf_ecc_pkg::ecc_syndrome_t chk, pos;
  logic                      wr_en, rd_en;

  //////////////////////////////
  // Encoder
  //////////////////////////////

  // Data bits sit on the non power of two positions 3, 5, 6, 7, 9 ... 38;
  // check bits are the XOR of the positions of all set data bits
  always_comb begin
    chk = '0;
    pos = 6'd2;
    for (int i = 0; i < `RF_DATA_W; i++) begin
      pos = pos + 6'd1;
      if ((pos & (pos - 6'd1)) == 6'd0) begin
        pos = pos + 6'd1;
      end
      if (wdata_i[i]) begin
        chk = chk ^ pos;
      end
    end
  end

  always_comb begin
    enc_word.data   = wdata_i;
    enc_word.check  = chk;
    enc_word.parity = ^{chk, wdata_i};
  end

  // Injected faults land in the stored word
  assign wr_word = enc_word ^ inj_mask_i;

  //////////////////////////////
  // Array
  //////////////////////////////

  assign wr_en = req_i & (op_i == rf_bus_pkg::RF_OP_WRITE) & (addr_i != '0);
  assign rd_en = req_i & (op_i == rf_bus_pkg::RF_OP_READ);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `RF_NUM_REGS; i++) begin
        mem_q[i] <= '0;
      end
      rd_word_q <= '0;
    end else begin
      if (wr_en) begin
        mem_q[addr_i] <= wr_word;
      end
      if (rd_en) begin
        rd_word_q <= mem_q[addr_i];
      end
    end
  end

  assign rd_word_o = rd_word_q;

endmodule

/* rf_bus_port.sv */
//////////////////////////////
// Register file bus port
// Wishbone classic slave, one store access per bus cycle
//////////////////////////////

`timescale 1ns/100ps
`include "rf_defs.svh"

module rf_bus_port (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_enable_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [`RF_ADDR_W-1:0]   wb_adr_i,
  input  logic [`RF_DATA_W-1:0]   wb_dat_i,
  input  logic [`RF_DATA_W-1:0]   rd_data_i,
  input  rf_ecc_pkg::ecc_status_e rd_status_i,
  output logic [`RF_DATA_W-1:0]   wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    wb_err_o,
  output logic                    req_o,
  output rf_bus_pkg::rf_op_e      op_o,
  output logic [`RF_ADDR_W-1:0]   addr_o,
  output logic [`RF_DATA_W-1:0]   wdata_o,
  output logic                    rd_valid_o,
  output logic                    core_sleep_o
);

  rf_bus_pkg::bus_state_e state_q, state_d;
  rf_bus_pkg::rf_op_e     op_q;
  logic                   fetch_enable_q;
  logic                   accept;
  logic                   resp_ack, resp_err;
  logic                   ack_q, err_q;
  logic [`RF_ADDR_W-1:0]  addr_q;
  logic [`RF_DATA_W-1:0]  wdata_q, dat_q;

  // Set once, cleared only by reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  // Blocked while the previous ack or err is still on the bus
  assign accept = fetch_enable_q & wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o &
                  (state_q == rf_bus_pkg::BUS_IDLE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      rf_bus_pkg::BUS_IDLE:   if (accept) state_d = rf_bus_pkg::BUS_ACCESS;
      rf_bus_pkg::BUS_ACCESS: state_d = rf_bus_pkg::BUS_RESP;
      rf_bus_pkg::BUS_RESP:   state_d = rf_bus_pkg::BUS_IDLE;
      default:                state_d = rf_bus_pkg::BUS_IDLE;
    endcase
  end

  assign rd_valid_o = (state_q == rf_bus_pkg::BUS_RESP) & (op_q == rf_bus_pkg::RF_OP_READ);
  assign resp_err   = rd_valid_o & (rd_status_i == rf_ecc_pkg::ECC_FATAL);
  assign resp_ack   = (state_q == rf_bus_pkg::BUS_RESP) & ~resp_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rf_bus_pkg::BUS_IDLE;
      op_q    <= rf_bus_pkg::RF_OP_READ;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= resp_ack;
      err_q   <= resp_err;
      if (accept) begin
        op_q <= wb_we_i ? rf_bus_pkg::RF_OP_WRITE : rf_bus_pkg::RF_OP_READ;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= wb_adr_i;
      wdata_q <= wb_dat_i;
    end
    if (state_q == rf_bus_pkg::BUS_RESP) begin
      dat_q <= rd_valid_o ? rd_data_i : '0;
    end
  end

  assign req_o        = (state_q == rf_bus_pkg::BUS_ACCESS);
  assign op_o         = op_q;
  assign addr_o       = addr_q;
  assign wdata_o      = wdata_q;
  assign wb_dat_o     = dat_q;
  assign wb_ack_o     = ack_q;
  assign wb_err_o     = err_q;
  assign core_sleep_o = ~fetch_enable_q | ((state_q == rf_bus_pkg::BUS_IDLE) & ~wb_cyc_i);

endmodule

/* rf_ecc_pkg.sv */
//////////////////////////////
// ECC types
// Stored codeword layout, syndrome and read status
//////////////////////////////

`include "rf_defs.svh"

package rf_ecc_pkg;

  // Bit 38 parity, bits 37..32 check, bits 31..0 data
  typedef struct packed {
    logic                    parity;
    logic [`RF_CHK_W-2:0]    check;
    logic [`RF_DATA_W-1:0]   data;
  } ecc_word_t;

  typedef logic [`RF_CHK_W-2:0] ecc_syndrome_t;

  typedef enum logic [1:0] {
    ECC_OK        = 2'd0,
    ECC_CORRECTED = 2'd1,
    ECC_FATAL     = 2'd2
  } ecc_status_e;

endpackage

/* rf_bus_pkg.sv */
//////////////////////////////
// Bus port types
// Access sequencing state and store opcode
//////////////////////////////

package rf_bus_pkg;

  // Bus port sequencing
  typedef enum logic [1:0] {
    BUS_IDLE   = 2'd0,
    BUS_ACCESS = 2'd1,
    BUS_RESP   = 2'd2
  } bus_state_e;

  // Store access kind
  typedef enum logic {
    RF_OP_READ  = 1'b0,
    RF_OP_WRITE = 1'b1
  } rf_op_e;

endpackage

/* rf_defs.svh */
//////////////////////////////
// Register file defines
// Widths and depth of the SECDED protected register file
//////////////////////////////

`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

// Data word and register address
`define RF_DATA_W    32
`define RF_ADDR_W    5

// Six Hamming check bits plus overall parity
`define RF_CHK_W     7
`define RF_CW_W      39
`define RF_NUM_REGS  32

`endif
